//--- verilog/uart_pkg.sv
/*
 * shared widths, register map, AXI response codes
 * and the receiver and transmitter state types
 */
`default_nettype none

package uart_pkg;

  // one UART character
  localparam int unsigned data_w = 8;

  // AXI4-Lite bus widths
  localparam int unsigned axil_addr_w = 4;
  localparam int unsigned axil_data_w = 32;

  // register byte offsets, anything else answers with SLVERR
  typedef enum logic [axil_addr_w-1:0] {
    reg_ctrl   = 4'h0,  // bit0 rx_en
    reg_status = 4'h4,  // bit0 rx_full, bit1 tx_busy
    reg_rxdata = 4'h8,  // read pops the received byte
    reg_txdata = 4'hc   // write sends a byte
  } reg_addr_e;

  // AXI response codes in use
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axi_resp_e;

  // receiver states, one-hot
  typedef enum logic [4:0] {
    rx_idle        = 5'b00001,
    rx_start       = 5'b00010,
    rx_data        = 5'b00100,
    rx_stop        = 5'b01000,
    rx_wait_go_low = 5'b10000
  } rx_state_e;

  // transmitter states
  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_e;

endpackage

`default_nettype wire

//--- verilog/uart_rx.sv
/*
 * uart_rx: 8N1 serial receiver with go / ready handshake
 */
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int unsigned clk_freq  = 100_000_000,
  parameter int unsigned baud_rate = 115_200
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       rxd,
  input  logic                       go,
  output logic [uart_pkg::data_w-1:0] data,
  output logic                       ready
);

  import uart_pkg::*;

  // clock cycles per serial bit
  localparam int unsigned bit_time = clk_freq / baud_rate;
  localparam int unsigned cnt_w    = (bit_time > 1) ? $clog2(bit_time) : 1;
  localparam int unsigned idx_w    = $clog2(data_w);

  // reload values, one less since the loading cycle already counts
  localparam logic [cnt_w-1:0] full_reload = cnt_w'(bit_time - 1);
  localparam logic [cnt_w-1:0] half_reload = cnt_w'((bit_time > 1) ? (bit_time / 2 - 1) : 0);

  rx_state_e        state;
  logic [cnt_w-1:0] bit_cnt;
  logic [idx_w-1:0] bit_idx;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= rx_idle;
      bit_cnt <= '0;
      bit_idx <= '0;
      data    <= '0;
      ready   <= 1'b0;
    end else begin
      case (state)
        rx_idle: begin
          // only look for a start bit when the register block wants a byte
          if (go && !rxd) begin
            bit_idx <= '0;
            // half a bit gets us to the centre of the start bit
            bit_cnt <= half_reload;
            state   <= rx_start;
          end
        end

        rx_start: begin
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == '0) begin
            bit_cnt <= full_reload;
            state   <= rx_data;
          end
        end

        rx_data: begin
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == '0) begin
            // mid-bit sample, LSB arrives first
            data[bit_idx] <= rxd;
            bit_cnt       <= full_reload;
            bit_idx       <= bit_idx + 1'b1;
            if (bit_idx == idx_w'(data_w - 1)) begin
              bit_idx <= '0;
              state   <= rx_stop;
            end
          end
        end

        rx_stop: begin
          // stop bit level is not checked
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == '0) begin
            ready <= 1'b1;
            state <= rx_wait_go_low;
          end
        end

        rx_wait_go_low: begin
          // byte stays valid until the consumer takes go away
          if (!go) begin
            data  <= '0;
            ready <= 1'b0;
            state <= rx_idle;
          end
        end

        default: begin
          state <= rx_idle;
          ready <= 1'b0;
        end
      endcase
    end
  end

  // ready only exists between the stop bit and the release of go
  a_no_ready_in_idle: assert property (
    @(posedge clk) disable iff (!rst_n) (state == rx_idle) |-> !ready
  );

  a_state_onehot: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot(state)
  );

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
/*
 * uart_tx: 8N1 serial transmitter started by a one-cycle pulse
 */
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int unsigned clk_freq  = 100_000_000,
  parameter int unsigned baud_rate = 115_200
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  logic [uart_pkg::data_w-1:0] data,
  output logic                       busy,
  output logic                       txd
);

  import uart_pkg::*;

  localparam int unsigned bit_time = clk_freq / baud_rate;
  localparam int unsigned cnt_w    = (bit_time > 1) ? $clog2(bit_time) : 1;
  localparam int unsigned idx_w    = $clog2(data_w);
  localparam logic [cnt_w-1:0] full_reload = cnt_w'(bit_time - 1);

  tx_state_e         state;
  logic [cnt_w-1:0]  bit_cnt;
  logic [idx_w-1:0]  bit_idx;
  logic [data_w-1:0] shreg;

  // busy covers start, data and stop bits
  assign busy = (state != tx_idle);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= tx_idle;
      bit_cnt <= '0;
      bit_idx <= '0;
      shreg   <= '0;
      txd     <= 1'b1;
    end else begin
      case (state)
        tx_idle: begin
          // start pulses while busy never reach here
          if (start) begin
            shreg   <= data;
            txd     <= 1'b0;
            bit_cnt <= full_reload;
            state   <= tx_start;
          end
        end

        tx_start: begin
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == '0) begin
            // first data bit, LSB first
            txd     <= shreg[0];
            shreg   <= shreg >> 1;
            bit_idx <= '0;
            bit_cnt <= full_reload;
            state   <= tx_data;
          end
        end

        tx_data: begin
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == '0) begin
            bit_cnt <= full_reload;
            if (bit_idx == idx_w'(data_w - 1)) begin
              // last bit done, drive the stop level
              txd   <= 1'b1;
              state <= tx_stop;
            end else begin
              txd     <= shreg[0];
              shreg   <= shreg >> 1;
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end

        tx_stop: begin
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == '0) begin
            state <= tx_idle;
          end
        end

        default: state <= tx_idle;
      endcase
    end
  end

  // line rests high between frames
  a_idle_line_high: assert property (
    @(posedge clk) disable iff (!rst_n) (state == tx_idle) |-> txd
  );

endmodule

`default_nettype wire

//--- verilog/uart_regs.sv
/*
 * AXI4-Lite slave with control, status,
 * rx data and tx data registers
 */
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
  input  logic                            clk,
  input  logic                            rst_n,
  // write address and data
  input  logic [uart_pkg::axil_addr_w-1:0] awaddr,
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [uart_pkg::axil_data_w-1:0] wdata,
  input  logic [uart_pkg::axil_data_w/8-1:0] wstrb,
  input  logic                            wvalid,
  output logic                            wready,
  // write response
  output logic [1:0]                      bresp,
  output logic                            bvalid,
  input  logic                            bready,
  // read address and data
  input  logic [uart_pkg::axil_addr_w-1:0] araddr,
  input  logic                            arvalid,
  output logic                            arready,
  output logic [uart_pkg::axil_data_w-1:0] rdata,
  output logic [1:0]                      rresp,
  output logic                            rvalid,
  input  logic                            rready,
  // receiver link
  output logic                            rx_go,
  input  logic [uart_pkg::data_w-1:0]      rx_data,
  input  logic                            rx_ready,
  // transmitter link
  output logic                            tx_start,
  output logic [uart_pkg::data_w-1:0]      tx_data,
  input  logic                            tx_busy
);

  import uart_pkg::*;

  logic              rx_en;
  logic              rx_full;
  logic [data_w-1:0] rx_byte;
  logic              tx_fire;

  // receiver runs only while enabled and there is room for a byte
  assign rx_go = rx_en && !rx_full;

  // a TXDATA write that finds the transmitter free
  // byte strobes are ignored and registers are always written whole
  assign tx_fire = awready && (awaddr == reg_txdata) && !tx_busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      awready  <= 1'b0;
      wready   <= 1'b0;
      bvalid   <= 1'b0;
      bresp    <= resp_okay;
      arready  <= 1'b0;
      rvalid   <= 1'b0;
      rresp    <= resp_okay;
      rdata    <= '0;
      rx_en    <= 1'b0;
      rx_full  <= 1'b0;
      rx_byte  <= '0;
      tx_start <= 1'b0;
    end else begin
      tx_start <= 1'b0;

      // write channel takes address and data together
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (awready) begin
        awready <= 1'b0;
        wready  <= 1'b0;
        bvalid  <= 1'b1;
        bresp   <= resp_okay;
        case (awaddr)
          reg_ctrl:   rx_en <= wdata[0];
          reg_status: ;
          reg_rxdata: ;
          // dropped silently when the transmitter is busy
          reg_txdata: tx_start <= tx_fire;
          default:    bresp <= resp_slverr;
        endcase
      end else if (awvalid && wvalid && !bvalid) begin
        awready <= 1'b1;
        wready  <= 1'b1;
      end

      // read channel
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
      if (arready) begin
        arready <= 1'b0;
        rvalid  <= 1'b1;
        rresp   <= resp_okay;
        rdata   <= '0;
        case (araddr)
          reg_ctrl:   rdata <= axil_data_w'(rx_en);
          reg_status: rdata <= axil_data_w'({tx_busy, rx_full});
          reg_rxdata: begin
            // reading pops the byte
            rdata   <= axil_data_w'(rx_byte);
            rx_full <= 1'b0;
          end
          reg_txdata: ;
          default:    rresp <= resp_slverr;
        endcase
      end else if (arvalid && !rvalid) begin
        arready <= 1'b1;
      end

      // capturing a finished byte also drops rx_go
      // and frees the receiver
      if (rx_ready && rx_go) begin
        rx_byte <= rx_data;
        rx_full <= 1'b1;
      end
    end
  end

  // outgoing byte for the transmitter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_data <= '0;
    end else if (tx_fire) begin
      tx_data <= wdata[data_w-1:0];
    end
  end

  // write response must wait for the master
  a_bvalid_hold: assert property (
    @(posedge clk) disable iff (!rst_n) (bvalid && !bready) |=> bvalid
  );

endmodule

`default_nettype wire

//--- verilog/uart_top.sv
/*
 * uart_top: AXI4-Lite UART, register block with receiver and transmitter
 */
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
  parameter int unsigned clk_freq  = 100_000_000,
  parameter int unsigned baud_rate = 115_200
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [uart_pkg::axil_addr_w-1:0] awaddr,
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [uart_pkg::axil_data_w-1:0] wdata,
  input  logic [uart_pkg::axil_data_w/8-1:0] wstrb,
  input  logic                            wvalid,
  output logic                            wready,
  output logic [1:0]                      bresp,
  output logic                            bvalid,
  input  logic                            bready,
  input  logic [uart_pkg::axil_addr_w-1:0] araddr,
  input  logic                            arvalid,
  output logic                            arready,
  output logic [uart_pkg::axil_data_w-1:0] rdata,
  output logic [1:0]                      rresp,
  output logic                            rvalid,
  input  logic                            rready,
  input  logic                            rxd,
  output logic                            txd
);

  import uart_pkg::*;

  // receiver handshake
  logic              rx_go;
  logic [data_w-1:0] rx_data;
  logic              rx_ready;
  // transmitter handshake
  logic              tx_start;
  logic [data_w-1:0] tx_data;
  logic              tx_busy;

  uart_regs uart_regs_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .rx_go    (rx_go),
    .rx_data  (rx_data),
    .rx_ready (rx_ready),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx_busy  (tx_busy)
  );

  uart_rx #(
    .clk_freq  (clk_freq),
    .baud_rate (baud_rate)
  ) uart_rx_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .rxd   (rxd),
    .go    (rx_go),
    .data  (rx_data),
    .ready (rx_ready)
  );

  uart_tx #(
    .clk_freq  (clk_freq),
    .baud_rate (baud_rate)
  ) uart_tx_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .start (tx_start),
    .data  (tx_data),
    .busy  (tx_busy),
    .txd   (txd)
  );

endmodule

`default_nettype wire

//--- bench/uart_top_tb.sv
/*
 * AXI4-Lite UART testbench with clock, reset, AXI master tasks,
 * serial driver and monitor, and a table of tests applied in a loop
 */
`timescale 1ns/1ps
`default_nettype none

module uart_top_tb;

  // 4 ns clock and 10 clocks per serial bit
  localparam int unsigned clk_freq   = 250_000_000;
  localparam int unsigned baud_rate  = 25_000_000;
  localparam int unsigned bit_cycles = clk_freq / baud_rate;
  localparam int unsigned clk_ns     = 4;
  localparam int unsigned bit_ns     = bit_cycles * clk_ns;

  // register offsets and response codes as seen by software
  localparam logic [3:0] addr_ctrl   = 4'h0;
  localparam logic [3:0] addr_status = 4'h4;
  localparam logic [3:0] addr_rxdata = 4'h8;
  localparam logic [3:0] addr_txdata = 4'hc;
  localparam logic [1:0] resp_ok     = 2'b00;
  localparam logic [1:0] resp_err    = 2'b10;

  localparam int unsigned n_tests     = 10;
  // 30 bit times per entry plus room for reset and the reset checks
  localparam int unsigned watchdog_ns = n_tests * 30 * bit_ns + 40 * bit_ns;
  // cycles to wait for any single handshake
  localparam int unsigned hs_limit    = 64;

  typedef enum {rx_frame, rx_disabled, tx_frame, bad_addr, ctrl_rw} kind_e;

  // value holds the byte or the offset for bad_addr
  string test_name [n_tests] = '{
    "ctrl_set", "ctrl_clear", "bad_addr_2", "bad_addr_f", "rx_a5",
    "rx_3c", "rx_off_5a", "tx_81", "tx_e7", "rx_00"
  };
  kind_e test_kind [n_tests] = '{
    ctrl_rw, ctrl_rw, bad_addr, bad_addr, rx_frame,
    rx_frame, rx_disabled, tx_frame, tx_frame, rx_frame
  };
  logic [7:0] test_value [n_tests] = '{
    8'h01, 8'hfe, 8'h02, 8'h0f, 8'ha5,
    8'h3c, 8'h5a, 8'h81, 8'he7, 8'h00
  };

  logic        clk;
  logic        rst_n;
  logic [3:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [3:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic        rxd;
  logic        txd;

  int   pass_count;
  int   fail_count;
  // what CTRL bit0 should hold
  logic rx_en_model;

  uart_top #(
    .clk_freq  (clk_freq),
    .baud_rate (baud_rate)
  ) uart_top_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .rxd     (rxd),
    .txd     (txd)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_ns / 2) clk = ~clk;
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("timeout after %0d ns, the run stopped making progress", watchdog_ns);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s expected 0x%08h actual 0x%08h", what, expected, actual);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  // all bus tasks start and end on a falling edge
  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hf;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    n = 0;
    while (!(awready && wready) && n < hs_limit) begin
      @(negedge clk);
      n++;
    end
    if (!(awready && wready)) begin
      $display("write to offset 0x%h was never accepted", addr);
      fail_count++;
      resp = 2'bxx;
    end else begin
      // handshake completes on the next rising edge
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      n = 0;
      while (!bvalid && n < hs_limit) begin
        @(negedge clk);
        n++;
      end
      if (!bvalid) begin
        $display("write to offset 0x%h got no response", addr);
        fail_count++;
        resp = 2'bxx;
      end else begin
        resp = bresp;
        @(negedge clk);
      end
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    n = 0;
    while (!arready && n < hs_limit) begin
      @(negedge clk);
      n++;
    end
    if (!arready) begin
      $display("read of offset 0x%h was never accepted", addr);
      fail_count++;
      data = 'x;
      resp = 2'bxx;
    end else begin
      @(negedge clk);
      arvalid = 1'b0;
      n = 0;
      while (!rvalid && n < hs_limit) begin
        @(negedge clk);
        n++;
      end
      if (!rvalid) begin
        $display("read of offset 0x%h got no data", addr);
        fail_count++;
        data = 'x;
        resp = 2'bxx;
      end else begin
        data = rdata;
        resp = rresp;
        @(negedge clk);
      end
    end
    arvalid = 1'b0;
    rready  = 1'b0;
  endtask

  // 8N1 frame on rxd with the LSB first
  task automatic send_frame(input logic [7:0] value);
    int i;
    rxd = 1'b0;
    repeat (bit_cycles) @(negedge clk);
    for (i = 0; i < 8; i++) begin
      rxd = value[i];
      repeat (bit_cycles) @(negedge clk);
    end
    rxd = 1'b1;
    repeat (bit_cycles) @(negedge clk);
  endtask

  task automatic capture_frame(input string name, output logic [7:0] value,
                               output logic stop_bit);
    int n;
    int i;
    n = 0;
    while (txd !== 1'b0 && n < hs_limit) begin
      @(negedge clk);
      n++;
    end
    if (txd !== 1'b0) begin
      $display("%s: txd never went low for a start bit", name);
      fail_count++;
      value    = 'x;
      stop_bit = 1'bx;
    end else begin
      // first low sample is up to a cycle late so step to mid start bit
      repeat (bit_cycles / 2 - 1) @(negedge clk);
      check({name, " start bit"}, 32'h0, {31'h0, txd});
      for (i = 0; i < 8; i++) begin
        repeat (bit_cycles) @(negedge clk);
        value[i] = txd;
      end
      repeat (bit_cycles) @(negedge clk);
      stop_bit = txd;
    end
  endtask

  // poll STATUS until rx_full for at most 12 bit times
  task automatic wait_rx_full(output logic [31:0] status);
    time         t0;
    logic [1:0]  resp;
    t0     = $time;
    status = '0;
    while (!status[0] && ($time - t0) < 12 * bit_ns) begin
      axi_read(addr_status, status, resp);
    end
  endtask

  task automatic reset_values();
    logic [31:0] rd;
    logic [1:0]  resp;
    axi_read(addr_status, rd, resp);
    check("reset status resp", {30'h0, resp_ok}, {30'h0, resp});
    check("reset status", 32'h0, rd);
    axi_read(addr_ctrl, rd, resp);
    check("reset ctrl resp", {30'h0, resp_ok}, {30'h0, resp});
    check("reset ctrl", 32'h0, rd);
    check("reset txd", 32'h1, {31'h0, txd});
  endtask

  task automatic ctrl_readback(input string name, input logic [7:0] value);
    logic [31:0] rd;
    logic [1:0]  resp;
    axi_write(addr_ctrl, {24'h0, value}, resp);
    check({name, " bresp"}, {30'h0, resp_ok}, {30'h0, resp});
    rx_en_model = value[0];
    // only bit0 is stored
    axi_read(addr_ctrl, rd, resp);
    check({name, " rresp"}, {30'h0, resp_ok}, {30'h0, resp});
    check({name, " ctrl"}, {31'h0, value[0]}, rd);
  endtask

  task automatic bad_address(input string name, input logic [3:0] addr);
    logic [31:0] rd;
    logic [1:0]  resp;
    axi_write(addr, 32'hffff_ffff, resp);
    check({name, " bresp"}, {30'h0, resp_err}, {30'h0, resp});
    // rejected write must leave CTRL alone
    axi_read(addr_ctrl, rd, resp);
    check({name, " ctrl kept"}, {31'h0, rx_en_model}, rd);
    axi_read(addr, rd, resp);
    check({name, " rresp"}, {30'h0, resp_err}, {30'h0, resp});
    check({name, " rdata"}, 32'h0, rd);
  endtask

  task automatic receive_byte(input string name, input logic [7:0] value);
    logic [31:0] rd;
    logic [31:0] status;
    logic [1:0]  resp;
    axi_write(addr_ctrl, 32'h1, resp);
    check({name, " ctrl bresp"}, {30'h0, resp_ok}, {30'h0, resp});
    rx_en_model = 1'b1;
    fork
      send_frame(value);
      wait_rx_full(status);
    join
    check({name, " rx_full set"}, 32'h1, status);
    // buffer is full so this frame has nowhere to go
    send_frame(~value);
    axi_read(addr_rxdata, rd, resp);
    check({name, " rxdata resp"}, {30'h0, resp_ok}, {30'h0, resp});
    check({name, " rxdata"}, {24'h0, value}, rd);
    axi_read(addr_status, rd, resp);
    check({name, " rx_full cleared"}, 32'h0, rd);
  endtask

  task automatic receive_disabled(input string name, input logic [7:0] value);
    logic [31:0] rd;
    logic [1:0]  resp;
    axi_write(addr_ctrl, 32'h0, resp);
    check({name, " ctrl bresp"}, {30'h0, resp_ok}, {30'h0, resp});
    rx_en_model = 1'b0;
    send_frame(value);
    // a receiver that wrongly started would finish within another bit
    repeat (bit_cycles) @(negedge clk);
    axi_read(addr_status, rd, resp);
    check({name, " status"}, 32'h0, rd);
  endtask

  task automatic transmit_byte(input string name, input logic [7:0] value);
    logic [31:0] st;
    logic [1:0]  resp;
    logic [7:0]  got;
    logic        stop_bit;
    int          n;
    fork
      capture_frame(name, got, stop_bit);
      begin
        axi_write(addr_txdata, {24'h0, value}, resp);
        check({name, " bresp"}, {30'h0, resp_ok}, {30'h0, resp});
        axi_read(addr_status, st, resp);
        check({name, " busy in frame"}, 32'h1, {31'h0, st[1]});
      end
    join
    check({name, " byte"}, {24'h0, value}, {24'h0, got});
    check({name, " stop bit"}, 32'h1, {31'h0, stop_bit});
    // busy drops once the stop bit has run its full length
    n  = 0;
    st = 32'h2;
    while (st[1] !== 1'b0 && n < 8) begin
      axi_read(addr_status, st, resp);
      n++;
    end
    check({name, " busy after"}, 32'h0, {31'h0, st[1]});
  endtask

  task automatic test_result(input string name, input int fails_before);
    if (fail_count == fails_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d failed checks", name, fail_count - fails_before);
    end
  endtask

  initial begin : main
    int          fails_before;
    int unsigned gap;
    int          t;
    rst_n       = 1'b0;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    rxd         = 1'b1;
    pass_count  = 0;
    fail_count  = 0;
    rx_en_model = 1'b0;
    void'($urandom(32'hb45178af));

    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    fails_before = fail_count;
    reset_values();
    test_result("reset_values", fails_before);

    for (t = 0; t < n_tests; t++) begin
      fails_before = fail_count;
      case (test_kind[t])
        ctrl_rw:     ctrl_readback(test_name[t], test_value[t]);
        bad_addr:    bad_address(test_name[t], test_value[t][3:0]);
        rx_frame:    receive_byte(test_name[t], test_value[t]);
        rx_disabled: receive_disabled(test_name[t], test_value[t]);
        tx_frame:    transmit_byte(test_name[t], test_value[t]);
        default: begin
          $display("%s: unknown test kind", test_name[t]);
          fail_count++;
        end
      endcase
      test_result(test_name[t], fails_before);
      // idle line of up to 15 cycles between tests
      gap = $urandom % 16;
      repeat (gap) @(negedge clk);
    end

    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- uart_top.f
verilog/uart_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/uart_regs.sv
verilog/uart_top.sv
bench/uart_top_tb.sv

//--- Bender.yml
package:
  name: uart_top

dependencies: {}

sources:
  # shared package first, then the blocks, then the top level
  - verilog/uart_pkg.sv
  - verilog/uart_rx.sv
  - verilog/uart_tx.sv
  - verilog/uart_regs.sv
  - verilog/uart_top.sv

  # testbench, only for simulation
  - target: test
    files:
      - bench/uart_top_tb.sv
